/* hw/bmc_pkg.sv */
package bmc_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // each slave owns one 16 word window, decoded on the bits above the offset
  localparam addr_t SYSCONF_BASE = 16'h0000;
  localparam addr_t IRQC_BASE    = 16'h0100;
  localparam addr_t BUSMON_BASE  = 16'h0200;
  localparam int    WINDOW_WORDS = 16;
  localparam int    OFF_W        = $clog2(WINDOW_WORDS);

  typedef logic [OFF_W-1:0] off_t;

  localparam int NUM_SLAVES  = 3;
  localparam int SLV_SYSCONF = 0;
  localparam int SLV_IRQC    = 1;
  localparam int SLV_BUSMON  = 2;

  localparam off_t REG_BOARD_ID   = 4'd0;
  localparam off_t REG_REVISION   = 4'd1;
  localparam off_t REG_CONFIG     = 4'd2;
  localparam off_t REG_IRQ_STATUS = 4'd0;
  localparam off_t REG_IRQ_MASK   = 4'd1;
  localparam off_t REG_BM_ADDR    = 4'd0;
  localparam off_t REG_BM_INFO    = 4'd1;

  localparam data_t BOARD_ID = 16'h0b3c;
  localparam data_t REVISION = 16'h0102;

  // a single master still needs a one bit id
  function automatic int id_width(int num_masters);
    return (num_masters > 1) ? $clog2(num_masters) : 1;
  endfunction

endpackage

/* hw/wbm_arbiter.sv */
`timescale 1ns/1ps

module wbm_arbiter #(
  parameter int NUM_MASTERS = 2
) (
  input  logic                                  gclk40,
  input  logic                                  hard_reset,
  input  logic             [NUM_MASTERS-1:0]    m_cyc_i,
  input  logic             [NUM_MASTERS-1:0]    m_stb_i,
  input  logic             [NUM_MASTERS-1:0]    m_we_i,
  input  bmc_pkg::addr_t   [NUM_MASTERS-1:0]    m_adr_i,
  input  bmc_pkg::data_t   [NUM_MASTERS-1:0]    m_dat_i,
  output bmc_pkg::data_t                        m_dat_o,
  output logic             [NUM_MASTERS-1:0]    m_ack_o,
  output logic             [NUM_MASTERS-1:0]    m_err_o,
  output logic                                  bus_cyc_o,
  output logic                                  bus_stb_o,
  output logic                                  bus_we_o,
  output bmc_pkg::addr_t                        bus_adr_o,
  output bmc_pkg::data_t                        bus_dat_o,
  output logic [bmc_pkg::id_width(NUM_MASTERS)-1:0] bus_id_o,
  input  bmc_pkg::data_t                        bus_dat_i,
  input  logic                                  bus_ack_i,
  input  logic                                  bus_err_i
);

  localparam int ID_W = bmc_pkg::id_width(NUM_MASTERS);

  logic            busy_q;
  logic [ID_W-1:0] owner_q;
  logic [ID_W-1:0] next_owner;
  logic            req_any;

  // fixed priority, the lowest numbered requester wins
  always_comb begin
    req_any    = 1'b0;
    next_owner = '0;
    for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
      if (m_cyc_i[i] && m_stb_i[i]) begin
        req_any    = 1'b1;
        next_owner = ID_W'(i);
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
    end else if (!busy_q) begin
      if (req_any) begin
        busy_q  <= 1'b1;
        owner_q <= next_owner;
      end
    end else if (bus_ack_i || bus_err_i || !m_cyc_i[owner_q]) begin
      busy_q <= 1'b0; // cycle finished or the owner gave up
    end
  end

  assign bus_cyc_o = busy_q && m_cyc_i[owner_q];
  assign bus_stb_o = busy_q && m_stb_i[owner_q];
  assign bus_we_o  = m_we_i[owner_q];
  assign bus_adr_o = m_adr_i[owner_q];
  assign bus_dat_o = m_dat_i[owner_q];
  assign bus_id_o  = owner_q;
  assign m_dat_o   = bus_dat_i; // read data is shared, only the owner gets an ack

  always_comb begin
    m_ack_o = '0;
    m_err_o = '0;
    if (busy_q) begin
      m_ack_o[owner_q] = bus_ack_i;
      m_err_o[owner_q] = bus_err_i;
    end
  end

  // the decoder and the slaves must never answer a cycle both ways
  a_ack_err_excl: assert property (@(posedge gclk40) disable iff (hard_reset)
    !(bus_ack_i && bus_err_i));

  // a granted master holds its address and direction until it is answered
  a_req_stable: assert property (@(posedge gclk40) disable iff (hard_reset)
    busy_q && bus_stb_o && !(bus_ack_i || bus_err_i) |=>
      $stable(bus_adr_o) && $stable(bus_we_o));

endmodule

/* hw/wbs_decoder.sv */
`timescale 1ns/1ps

module wbs_decoder #(
  parameter int NUM_MASTERS = 2
) (
  input  logic                                      gclk40,
  input  logic                                      hard_reset,
  input  logic                                      bus_cyc_i,
  input  logic                                      bus_stb_i,
  input  logic                                      bus_we_i,
  input  bmc_pkg::addr_t                            bus_adr_i,
  input  bmc_pkg::data_t                            bus_dat_i,
  input  logic [bmc_pkg::id_width(NUM_MASTERS)-1:0] bus_id_i,
  output bmc_pkg::data_t                            bus_dat_o,
  output logic                                      bus_ack_o,
  output logic                                      bus_err_o,
  output logic [bmc_pkg::NUM_SLAVES-1:0]            s_sel_o,
  output bmc_pkg::off_t                             s_off_o,
  output logic                                      s_we_o,
  output bmc_pkg::data_t                            s_dat_o,
  input  bmc_pkg::data_t [bmc_pkg::NUM_SLAVES-1:0]  s_dat_i,
  input  logic [bmc_pkg::NUM_SLAVES-1:0]            s_ack_i,
  output logic                                      viol_o,
  output bmc_pkg::addr_t                            viol_adr_o,
  output logic [bmc_pkg::id_width(NUM_MASTERS)-1:0] viol_id_o,
  output logic                                      viol_we_o
);

  localparam int HI = bmc_pkg::ADDR_W - 1;
  localparam int LO = bmc_pkg::OFF_W;

  logic                           access;
  logic [bmc_pkg::NUM_SLAVES-1:0] hit;

  assign access = bus_cyc_i && bus_stb_i;

  // window match on the bits above the offset
  always_comb begin
    hit = '0;
    hit[bmc_pkg::SLV_SYSCONF] = bus_adr_i[HI:LO] == bmc_pkg::SYSCONF_BASE[HI:LO];
    hit[bmc_pkg::SLV_IRQC]    = bus_adr_i[HI:LO] == bmc_pkg::IRQC_BASE[HI:LO];
    hit[bmc_pkg::SLV_BUSMON]  = bus_adr_i[HI:LO] == bmc_pkg::BUSMON_BASE[HI:LO];
  end

  assign s_sel_o = access ? hit : '0;
  assign s_off_o = bus_adr_i[LO-1:0];
  assign s_we_o  = bus_we_i;
  assign s_dat_o = bus_dat_i;

  // an unmapped strobe is refused at once
  assign viol_o     = access && (hit == '0);
  assign viol_adr_o = bus_adr_i;
  assign viol_id_o  = bus_id_i;
  assign viol_we_o  = bus_we_i;
  assign bus_err_o  = viol_o;

  always_comb begin
    bus_dat_o = '0;
    for (int i = 0; i < bmc_pkg::NUM_SLAVES; i++) begin
      if (s_sel_o[i]) begin
        bus_dat_o = bus_dat_o | s_dat_i[i];
      end
    end
  end

  assign bus_ack_o = |(s_sel_o & s_ack_i);

  // a slave may answer only while the decoder selects it
  a_ack_selected: assert property (@(posedge gclk40) disable iff (hard_reset)
    (s_ack_i & ~s_sel_o) == '0);

endmodule

/* hw/sys_config.sv */
`timescale 1ns/1ps

module sys_config (
  input  logic           gclk40,
  input  logic           hard_reset,
  input  logic           sel_i,
  input  bmc_pkg::off_t  off_i,
  input  logic           we_i,
  input  bmc_pkg::data_t dat_i,
  output bmc_pkg::data_t dat_o,
  output logic           ack_o,
  output logic [7:0]     sys_config_o
);

  logic [7:0]     config_q;
  logic           start;
  bmc_pkg::data_t rdata;

  // the access is taken once, in the first select cycle
  assign start = sel_i && !ack_o;

  always_comb begin
    case (off_i)
      bmc_pkg::REG_BOARD_ID: rdata = bmc_pkg::BOARD_ID;
      bmc_pkg::REG_REVISION: rdata = bmc_pkg::REVISION;
      bmc_pkg::REG_CONFIG:   rdata = {8'h00, config_q};
      default:               rdata = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      ack_o    <= 1'b0;
      config_q <= '0;
    end else begin
      ack_o <= start;
      if (start && we_i && off_i == bmc_pkg::REG_CONFIG) begin
        config_q <= dat_i[7:0]; // only the low byte exists
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (start) begin
      dat_o <= rdata;
    end
  end

  assign sys_config_o = config_q;

endmodule

/* hw/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller #(
  parameter int NUM_IRQ_SOURCES = 2
) (
  input  logic                       gclk40,
  input  logic                       hard_reset,
  input  logic                       sel_i,
  input  bmc_pkg::off_t              off_i,
  input  logic                       we_i,
  input  bmc_pkg::data_t             dat_i,
  input  logic [NUM_IRQ_SOURCES-1:0] irq_src_i,
  output bmc_pkg::data_t             dat_o,
  output logic                       ack_o,
  output logic                       irq_o
);

  logic [NUM_IRQ_SOURCES-1:0] status_q;
  logic [NUM_IRQ_SOURCES-1:0] mask_q;
  logic [NUM_IRQ_SOURCES-1:0] clr;
  logic                       wr;
  bmc_pkg::data_t             rdata;

  assign wr  = sel_i && !ack_o && we_i;
  assign clr = (wr && off_i == bmc_pkg::REG_IRQ_STATUS) ? dat_i[NUM_IRQ_SOURCES-1:0] : '0;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      ack_o    <= 1'b0;
      status_q <= '0;
      mask_q   <= '0;
    end else begin
      ack_o    <= sel_i && !ack_o;
      status_q <= (status_q & ~clr) | irq_src_i; // a new pulse beats a clear on the same edge
      if (wr && off_i == bmc_pkg::REG_IRQ_MASK) begin
        mask_q <= dat_i[NUM_IRQ_SOURCES-1:0];
      end
    end
  end

  always_comb begin
    case (off_i)
      bmc_pkg::REG_IRQ_STATUS: rdata = bmc_pkg::data_t'(status_q);
      bmc_pkg::REG_IRQ_MASK:   rdata = bmc_pkg::data_t'(mask_q);
      default:                 rdata = '0;
    endcase
  end

  always_ff @(posedge gclk40) begin
    if (sel_i && !ack_o) begin
      dat_o <= rdata;
    end
  end

  // level output, held until software clears the status bit
  assign irq_o = |(status_q & mask_q);

endmodule

/* hw/bus_monitor.sv */
`timescale 1ns/1ps

module bus_monitor #(
  parameter int NUM_MASTERS = 2
) (
  input  logic                                      gclk40,
  input  logic                                      hard_reset,
  input  logic                                      sel_i,
  input  bmc_pkg::off_t                             off_i,
  input  logic                                      we_i,
  input  logic                                      viol_i,
  input  bmc_pkg::addr_t                            viol_adr_i,
  input  logic [bmc_pkg::id_width(NUM_MASTERS)-1:0] viol_id_i,
  input  logic                                      viol_we_i,
  output bmc_pkg::data_t                            dat_o,
  output logic                                      ack_o,
  output logic                                      memv_o
);

  localparam int ID_W = bmc_pkg::id_width(NUM_MASTERS);

  bmc_pkg::addr_t  adr_q;
  logic [ID_W-1:0] id_q;
  logic            we_q;
  logic            valid_q;
  bmc_pkg::data_t  info;

  // captured fields of the last refused access
  always_ff @(posedge gclk40) begin
    if (viol_i) begin
      adr_q <= viol_adr_i;
      id_q  <= viol_id_i;
      we_q  <= viol_we_i;
    end
  end

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      ack_o   <= 1'b0;
      valid_q <= 1'b0;
      memv_o  <= 1'b0;
    end else begin
      ack_o  <= sel_i && !ack_o;
      memv_o <= viol_i;
      if (viol_i) begin
        valid_q <= 1'b1;
      end else if (sel_i && !ack_o && we_i && off_i == bmc_pkg::REG_BM_INFO) begin
        valid_q <= 1'b0; // any write acknowledges the capture
      end
    end
  end

  always_comb begin
    info           = '0;
    info[15]       = valid_q;
    info[8]        = we_q;
    info[ID_W-1:0] = id_q;
  end

  always_ff @(posedge gclk40) begin
    if (sel_i && !ack_o) begin
      case (off_i)
        bmc_pkg::REG_BM_ADDR: dat_o <= adr_q;
        bmc_pkg::REG_BM_INFO: dat_o <= info;
        default:              dat_o <= '0;
      endcase
    end
  end

endmodule

/* hw/debouncer.sv */
`timescale 1ns/1ps

module debouncer #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic gclk40,
  input  logic hard_reset,
  input  logic switch_i,
  output logic debounced_o,
  output logic pulse_o
);

  localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES - 1);

  logic [1:0]       sync_q; // two flop synchronizer for the raw switch
  logic             prev_q;
  logic [CNT_W-1:0] cnt_q;
  logic             level_d;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      sync_q      <= '0;
      prev_q      <= 1'b0;
      cnt_q       <= '0;
      debounced_o <= 1'b0;
      level_d     <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], switch_i};
      prev_q  <= sync_q[1];
      level_d <= debounced_o;
      if (sync_q[1] != prev_q) begin
        cnt_q <= '0; // any bounce starts the wait again
      end else if (cnt_q != CNT_MAX) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        debounced_o <= sync_q[1];
      end
    end
  end

  assign pulse_o = debounced_o && !level_d;

endmodule

/* hw/bmc_top.sv */
`timescale 1ns/1ps

module bmc_top #(
  parameter int NUM_MASTERS     = 2,
  parameter int DEBOUNCE_CYCLES = 16,
  parameter int NUM_IRQ_SOURCES = 2
) (
  input  logic                           gclk40,
  input  logic                           hard_reset,
  input  logic           [NUM_MASTERS-1:0] m_cyc_i,
  input  logic           [NUM_MASTERS-1:0] m_stb_i,
  input  logic           [NUM_MASTERS-1:0] m_we_i,
  input  bmc_pkg::addr_t [NUM_MASTERS-1:0] m_adr_i,
  input  bmc_pkg::data_t [NUM_MASTERS-1:0] m_dat_i,
  output bmc_pkg::data_t                 m_dat_o,
  output logic           [NUM_MASTERS-1:0] m_ack_o,
  output logic           [NUM_MASTERS-1:0] m_err_o,
  input  logic                           chs_powerdown_n_i,
  output logic                           irq_o,
  output logic [7:0]                     sys_config_o
);

  localparam int ID_W = bmc_pkg::id_width(NUM_MASTERS);

  logic                      bus_cyc, bus_stb, bus_we, bus_ack, bus_err;
  bmc_pkg::addr_t            bus_adr;
  bmc_pkg::data_t            bus_dat_w, bus_dat_r;
  logic [ID_W-1:0]           bus_id;

  logic [bmc_pkg::NUM_SLAVES-1:0]           s_sel, s_ack;
  bmc_pkg::off_t                            s_off;
  logic                                     s_we;
  bmc_pkg::data_t                           s_dat_w;
  bmc_pkg::data_t [bmc_pkg::NUM_SLAVES-1:0] s_dat_r;

  logic            viol, viol_we, memv;
  bmc_pkg::addr_t  viol_adr;
  logic [ID_W-1:0] viol_id;

  logic                       btn_pulse;
  logic [NUM_IRQ_SOURCES-1:0] irq_src;

  wbm_arbiter #(.NUM_MASTERS(NUM_MASTERS)) u_wbm_arbiter (
    .gclk40, .hard_reset,
    .m_cyc_i, .m_stb_i, .m_we_i, .m_adr_i, .m_dat_i,
    .m_dat_o, .m_ack_o, .m_err_o,
    .bus_cyc_o(bus_cyc), .bus_stb_o(bus_stb), .bus_we_o(bus_we),
    .bus_adr_o(bus_adr), .bus_dat_o(bus_dat_w), .bus_id_o(bus_id),
    .bus_dat_i(bus_dat_r), .bus_ack_i(bus_ack), .bus_err_i(bus_err)
  );

  wbs_decoder #(.NUM_MASTERS(NUM_MASTERS)) u_wbs_decoder (
    .gclk40, .hard_reset,
    .bus_cyc_i(bus_cyc), .bus_stb_i(bus_stb), .bus_we_i(bus_we),
    .bus_adr_i(bus_adr), .bus_dat_i(bus_dat_w), .bus_id_i(bus_id),
    .bus_dat_o(bus_dat_r), .bus_ack_o(bus_ack), .bus_err_o(bus_err),
    .s_sel_o(s_sel), .s_off_o(s_off), .s_we_o(s_we), .s_dat_o(s_dat_w),
    .s_dat_i(s_dat_r), .s_ack_i(s_ack),
    .viol_o(viol), .viol_adr_o(viol_adr), .viol_id_o(viol_id), .viol_we_o(viol_we)
  );

  sys_config u_sys_config (
    .gclk40, .hard_reset,
    .sel_i(s_sel[bmc_pkg::SLV_SYSCONF]), .off_i(s_off), .we_i(s_we), .dat_i(s_dat_w),
    .dat_o(s_dat_r[bmc_pkg::SLV_SYSCONF]), .ack_o(s_ack[bmc_pkg::SLV_SYSCONF]),
    .sys_config_o
  );

  // button press on source 0, refused bus access on source 1
  always_comb begin
    irq_src    = '0;
    irq_src[0] = btn_pulse;
    irq_src[1] = memv;
  end

  irq_controller #(.NUM_IRQ_SOURCES(NUM_IRQ_SOURCES)) u_irq_controller (
    .gclk40, .hard_reset,
    .sel_i(s_sel[bmc_pkg::SLV_IRQC]), .off_i(s_off), .we_i(s_we), .dat_i(s_dat_w),
    .irq_src_i(irq_src),
    .dat_o(s_dat_r[bmc_pkg::SLV_IRQC]), .ack_o(s_ack[bmc_pkg::SLV_IRQC]),
    .irq_o
  );

  bus_monitor #(.NUM_MASTERS(NUM_MASTERS)) u_bus_monitor (
    .gclk40, .hard_reset,
    .sel_i(s_sel[bmc_pkg::SLV_BUSMON]), .off_i(s_off), .we_i(s_we),
    .viol_i(viol), .viol_adr_i(viol_adr), .viol_id_i(viol_id), .viol_we_i(viol_we),
    .dat_o(s_dat_r[bmc_pkg::SLV_BUSMON]), .ack_o(s_ack[bmc_pkg::SLV_BUSMON]),
    .memv_o(memv)
  );

  debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_debouncer (
    .gclk40, .hard_reset,
    .switch_i(!chs_powerdown_n_i), // the chassis button pulls low when pressed
    .debounced_o(),
    .pulse_o(btn_pulse)
  );

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
  parameter int NUM_MASTERS     = 2,
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic                             gclk40,
  input  logic                             hard_reset,
  input  logic           [NUM_MASTERS-1:0] m_stb_i,
  input  logic           [NUM_MASTERS-1:0] m_we_i,
  input  bmc_pkg::addr_t [NUM_MASTERS-1:0] m_adr_i,
  input  bmc_pkg::data_t [NUM_MASTERS-1:0] m_dat_i,
  input  bmc_pkg::data_t                   rdat_i,
  input  logic           [NUM_MASTERS-1:0] m_ack_i,
  input  logic           [NUM_MASTERS-1:0] m_err_i,
  input  logic                             chs_powerdown_n_i,
  input  logic                             irq_i,
  input  logic [7:0]                       sys_config_i,
  input  logic [3:0]                       test_i,
  output logic                             done_o,
  output int                               errors_o
);

  localparam int ID_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  // register model, updated when an access completes
  logic [7:0]      config_m;
  logic [1:0]      status_m;
  logic [1:0]      mask_m;
  bmc_pkg::addr_t  bm_adr_m;
  logic [ID_W-1:0] bm_id_m;
  logic            bm_we_m;
  logic            bm_valid_m;
  int              held; // cycles the button has been held down
  logic [3:0]      last_test;
  int              test_checks;
  int              test_errors;
  int              total_checks;
  int              tests_run;
  logic [17:0]     resp_exp;

  // expected {err, irq_o, read data} of one access against the model
  function automatic logic [17:0] expect_resp(input logic we, input bmc_pkg::addr_t adr,
                                              input bmc_pkg::data_t wdat);
    logic [3:0]     off;
    logic [1:0]     st;
    logic [1:0]     mk;
    logic           err;
    bmc_pkg::data_t rd;
    off = adr[3:0];
    st  = status_m;
    mk  = mask_m;
    err = 1'b0;
    rd  = '0;
    case (adr[15:4])
      12'h000: begin
        case (off)
          4'd0:    rd = 16'h0b3c;
          4'd1:    rd = 16'h0102;
          4'd2:    rd = {8'h00, config_m};
          default: rd = '0;
        endcase
      end
      12'h010: begin
        case (off)
          4'd0:    rd = {14'h0, st};
          4'd1:    rd = {14'h0, mk};
          default: rd = '0;
        endcase
        if (we && off == 4'd0) begin
          st = st & ~wdat[1:0]; // write one to clear
        end else if (we && off == 4'd1) begin
          mk = wdat[1:0];
        end
      end
      12'h020: begin
        if (off == 4'd0) begin
          rd = bm_adr_m;
        end else if (off == 4'd1) begin
          rd[15]       = bm_valid_m;
          rd[8]        = bm_we_m;
          rd[ID_W-1:0] = bm_id_m;
        end
      end
      default: err = 1'b1;
    endcase
    return {err, |(st & mk), rd};
  endfunction

  task automatic update_model(input int m);
    bmc_pkg::addr_t adr;
    adr = m_adr_i[m];
    if (m_err_i[m]) begin
      bm_adr_m    = adr;
      bm_id_m     = ID_W'(m);
      bm_we_m     = m_we_i[m];
      bm_valid_m  = 1'b1;
      status_m[1] = 1'b1;
    end else if (m_we_i[m]) begin
      if (adr[15:4] == 12'h000 && adr[3:0] == 4'd2) begin
        config_m = m_dat_i[m][7:0];
      end else if (adr[15:4] == 12'h010 && adr[3:0] == 4'd0) begin
        status_m = status_m & ~m_dat_i[m][1:0];
      end else if (adr[15:4] == 12'h010 && adr[3:0] == 4'd1) begin
        mask_m = m_dat_i[m][1:0];
      end else if (adr[15:4] == 12'h020 && adr[3:0] == 4'd1) begin
        bm_valid_m = 1'b0;
      end
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
    test_checks++;
    if (exp !== got) begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, got);
      test_errors++;
    end
  endtask

  task automatic flag_failure(input string what);
    test_checks++;
    test_errors++;
    $display("%s at time %0t", what, $time);
  endtask

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset state";
      4'd2:    return "configuration registers";
      4'd3:    return "unmapped access capture";
      4'd4:    return "violation interrupt";
      4'd5:    return "two master arbitration";
      4'd6:    return "button debounce";
      default: return "unnamed";
    endcase
  endfunction

  task automatic report_test(input logic [3:0] id);
    $display("test %0d %s: %0d checks, %0d errors", id, test_name(id), test_checks,
             test_errors);
    total_checks += test_checks;
    errors_o     += test_errors;
    tests_run++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // outputs are sampled on the falling edge, half a cycle after the DUT moved
  always @(negedge gclk40) begin
    if (hard_reset) begin
      config_m     = '0;
      status_m     = '0;
      mask_m       = '0;
      bm_adr_m     = '0;
      bm_id_m      = '0;
      bm_we_m      = 1'b0;
      bm_valid_m   = 1'b0;
      held         = 0;
      last_test    = '0;
      test_checks  = 0;
      test_errors  = 0;
      total_checks = 0;
      tests_run    = 0;
      errors_o     = 0;
      done_o       = 1'b0;
    end else begin
      if (test_i != last_test) begin
        if (last_test != 4'd0) begin
          report_test(last_test);
        end
        if (test_i == 4'hf) begin
          $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, errors_o);
          done_o = 1'b1;
        end
        last_test = test_i;
      end
      // a press that stays for the full debounce time raises source 0
      if (!chs_powerdown_n_i) begin
        held++;
        if (held == DEBOUNCE_CYCLES) begin
          status_m[0] = 1'b1;
        end
      end else begin
        held = 0;
      end
      if (test_i == 4'd1) begin
        check_value("irq_o", 16'(1'b0), 16'(irq_i));
        check_value("sys_config_o", 16'h0000, 16'(sys_config_i));
        check_value("m_ack_o", 16'h0000, 16'(m_ack_i));
        check_value("m_err_o", 16'h0000, 16'(m_err_i));
      end
      if ($countones(m_ack_i) > 1) begin
        flag_failure("two masters were acknowledged in the same cycle");
      end
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (m_ack_i[m] && m_err_i[m]) begin
          flag_failure($sformatf("master %0d saw ack and err together", m));
        end
        if ((m_ack_i[m] || m_err_i[m]) && !m_stb_i[m]) begin
          flag_failure($sformatf("master %0d got a response without a request", m));
        end
        if (m_ack_i[m] || m_err_i[m]) begin
          resp_exp = expect_resp(m_we_i[m], m_adr_i[m], m_dat_i[m]);
          check_value($sformatf("m_err_o[%0d]", m), 16'(resp_exp[17]), 16'(m_err_i[m]));
          if (m_ack_i[m] && !m_we_i[m]) begin
            check_value("m_dat_o", resp_exp[15:0], rdat_i);
          end
          check_value("irq_o", 16'(resp_exp[16]), 16'(irq_i));
          update_model(m);
          check_value("sys_config_o", 16'(config_m), 16'(sys_config_i));
        end
      end
    end
  end

endmodule

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int NUM_MASTERS     = 2;
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int ACK_TIMEOUT     = 50;
  localparam int IRQ_TIMEOUT     = 100;
  localparam int DONE_TIMEOUT    = 10;

  logic                             gclk40;
  logic                             hard_reset;
  logic           [NUM_MASTERS-1:0] m_cyc;
  logic           [NUM_MASTERS-1:0] m_stb;
  logic           [NUM_MASTERS-1:0] m_we;
  bmc_pkg::addr_t [NUM_MASTERS-1:0] m_adr;
  bmc_pkg::data_t [NUM_MASTERS-1:0] m_dat;
  bmc_pkg::data_t                   rdat;
  logic           [NUM_MASTERS-1:0] m_ack;
  logic           [NUM_MASTERS-1:0] m_err;
  logic                             chs_powerdown_n;
  logic                             irq;
  logic [7:0]                       sys_config;
  logic [3:0]                       test_id;
  logic                             chk_done;
  int                               chk_errors;
  logic                             timed_out;
  logic [31:0]                      rng;

  bmc_top u_dut (
    .gclk40, .hard_reset,
    .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr), .m_dat_i(m_dat),
    .m_dat_o(rdat), .m_ack_o(m_ack), .m_err_o(m_err),
    .chs_powerdown_n_i(chs_powerdown_n),
    .irq_o(irq),
    .sys_config_o(sys_config)
  );

  tb_checker #(.NUM_MASTERS(NUM_MASTERS), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_checker (
    .gclk40, .hard_reset,
    .m_stb_i(m_stb), .m_we_i(m_we), .m_adr_i(m_adr), .m_dat_i(m_dat),
    .rdat_i(rdat), .m_ack_i(m_ack), .m_err_i(m_err),
    .chs_powerdown_n_i(chs_powerdown_n), .irq_i(irq), .sys_config_i(sys_config),
    .test_i(test_id), .done_o(chk_done), .errors_o(chk_errors)
  );

  initial begin
    gclk40 = 1'b0;
    forever #10 gclk40 = ~gclk40;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // true when the address falls outside all three slave windows
  function automatic logic unmapped(input bmc_pkg::addr_t adr);
    return adr[15:4] != 12'h000 && adr[15:4] != 12'h010 && adr[15:4] != 12'h020;
  endfunction

  task automatic start_test(input logic [3:0] id);
    @(posedge gclk40);
    test_id <= id;
  endtask

  // one Wishbone access, held until ack or err and then released for a cycle
  task automatic bus_access(input int m, input logic we, input bmc_pkg::addr_t adr,
                            input bmc_pkg::data_t wdat);
    int waited;
    waited = 0;
    @(posedge gclk40);
    m_cyc[m] <= 1'b1;
    m_stb[m] <= 1'b1;
    m_we[m]  <= we;
    m_adr[m] <= adr;
    m_dat[m] <= wdat;
    @(negedge gclk40);
    while (!(m_ack[m] || m_err[m]) && waited < ACK_TIMEOUT) begin
      @(negedge gclk40);
      waited++;
    end
    if (!(m_ack[m] || m_err[m])) begin
      $display("master %0d got neither ack nor err for address %h", m, adr);
      timed_out = 1'b1;
    end
    @(posedge gclk40);
    m_cyc[m] <= 1'b0;
    m_stb[m] <= 1'b0;
  endtask

  task automatic bus_write(input int m, input bmc_pkg::addr_t adr, input bmc_pkg::data_t wdat);
    bus_access(m, 1'b1, adr, wdat);
  endtask

  task automatic bus_read(input int m, input bmc_pkg::addr_t adr);
    bus_access(m, 1'b0, adr, 16'h0000);
  endtask

  initial begin
    wait (timed_out === 1'b1);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    bmc_pkg::addr_t adr;
    int             waited;
    hard_reset      = 1'b1;
    m_cyc           = '0;
    m_stb           = '0;
    m_we            = '0;
    m_adr           = '0;
    m_dat           = '0;
    chs_powerdown_n = 1'b1; // button released
    test_id         = '0;
    timed_out       = 1'b0;
    rng             = 32'hc8be_8bc0;
    repeat (3) @(posedge gclk40);
    hard_reset <= 1'b0;

    start_test(4'd1);
    repeat (8) @(posedge gclk40);

    start_test(4'd2);
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      bus_write(i % 2, 16'h0002, rng[15:0]);
      bus_read(i % 2, 16'h0002);
    end
    bus_write(0, 16'h0000, 16'hffff);
    bus_write(1, 16'h0001, 16'h5a5a);
    bus_read(0, 16'h0000);
    bus_read(1, 16'h0001);
    bus_read(0, 16'h0007); // unused offset

    start_test(4'd3);
    for (int i = 0; i < 4; i++) begin
      do begin
        rng = xorshift32(rng);
      end while (!unmapped(rng[15:0]));
      adr = rng[15:0];
      rng = xorshift32(rng);
      bus_access(i % 2, rng[20], adr, rng[15:0]);
      bus_read(0, 16'h0200);
      bus_read(1, 16'h0201);
      bus_write(0, 16'h0201, 16'h0000);
      bus_read(1, 16'h0201);
    end

    start_test(4'd4);
    bus_read(0, 16'h0100);
    bus_access(1, 1'b0, 16'h8000, 16'h0000); // another refused access while masked
    bus_read(0, 16'h0100);
    bus_write(1, 16'h0101, 16'h0002);
    bus_read(1, 16'h0101);
    bus_write(0, 16'h0100, 16'h0002);
    bus_read(0, 16'h0100);

    start_test(4'd5);
    fork
      bus_read(0, 16'h0000);
      bus_read(1, 16'h0001);
    join
    fork
      bus_write(0, 16'h0002, 16'h00a5);
      bus_read(1, 16'h0101);
    join
    fork
      bus_read(1, 16'h0002);
      bus_read(0, 16'h0201);
    join

    start_test(4'd6);
    bus_write(0, 16'h0101, 16'h0001);
    @(posedge gclk40);
    chs_powerdown_n <= 1'b0;
    repeat (DEBOUNCE_CYCLES / 4) @(posedge gclk40);
    chs_powerdown_n <= 1'b1;
    repeat (3 * DEBOUNCE_CYCLES) @(posedge gclk40);
    bus_read(0, 16'h0100);
    @(posedge gclk40);
    chs_powerdown_n <= 1'b0;
    repeat (2 * DEBOUNCE_CYCLES) @(posedge gclk40);
    chs_powerdown_n <= 1'b1;
    waited = 0;
    @(negedge gclk40);
    while (!irq && waited < IRQ_TIMEOUT) begin
      @(negedge gclk40);
      waited++;
    end
    if (!irq) begin
      $display("button press did not raise irq_o within %0d cycles", IRQ_TIMEOUT);
      timed_out = 1'b1;
    end
    bus_read(1, 16'h0100);
    bus_write(0, 16'h0100, 16'h0001);
    bus_read(0, 16'h0100);

    start_test(4'hf); // end of run, the checker closes its report
    waited = 0;
    while (!chk_done && waited < DONE_TIMEOUT) begin
      @(posedge gclk40);
      waited++;
    end
    if (!chk_done) begin
      $display("checker did not close its report");
      timed_out = 1'b1;
    end
    if (!timed_out) begin
      if (chk_errors == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

/* vlog.f */
hw/bmc_pkg.sv
hw/wbm_arbiter.sv
hw/wbs_decoder.sv
hw/sys_config.sv
hw/irq_controller.sv
hw/bus_monitor.sv
hw/debouncer.sv
hw/bmc_top.sv
test/tb_checker.sv
test/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f vlog.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"
